// File: hdl/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ways per set
`define ICACHE_WAYS 2

// sets selected by address bits 10 to 5
`define ICACHE_SETS 64

// 64-bit words per line
`define ICACHE_LINE_WORDS 4

// per-way saturating age counter width
`define ICACHE_AGE_W 4

`endif

// File: hdl/icache_addr_pkg.sv
`include "icache_settings.svh"

package icache_addr_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] word_t;
  typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;
  typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

  // byte offset inside a word, then word select, then index
  localparam int unsigned WORD_LSB = $clog2($bits(word_t) / 8);
  localparam int unsigned INDEX_LSB = WORD_LSB + $bits(word_sel_t);
  localparam int unsigned TAG_LSB = INDEX_LSB + $bits(index_t);

  typedef logic [$bits(addr_t)-TAG_LSB-1:0] tag_t;

  typedef struct packed {
    logic  req;
    addr_t addr;
  } fetch_req_s;

  function automatic tag_t addr_tag(addr_t a);
    return a[$bits(addr_t)-1:TAG_LSB];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[INDEX_LSB +: $bits(index_t)];
  endfunction

  function automatic word_sel_t addr_word(addr_t a);
    return a[WORD_LSB +: $bits(word_sel_t)];
  endfunction

  // line base with the offset bits cleared
  function automatic addr_t line_addr(addr_t a);
    return a & ~addr_t'((1 << INDEX_LSB) - 1);
  endfunction

endpackage

// File: hdl/icache_line_pkg.sv
`include "icache_settings.svh"

package icache_line_pkg;

  // word 0 sits in the low bits
  typedef icache_addr_pkg::word_t [`ICACHE_LINE_WORDS-1:0] line_t;

  typedef logic [`ICACHE_AGE_W-1:0] age_t;

  typedef struct packed {
    logic                  valid;
    icache_addr_pkg::tag_t tag;
    line_t                 line;
  } way_entry_s;

  // per-way commands from the hit and replacement logic
  typedef struct packed {
    logic fill;
    logic touch;
    logic age_up;
  } way_ctl_s;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WRITE,
    REPLAY
  } refill_state_e;

endpackage

// File: hdl/icache_way.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way (
  input  logic                        clk,
  input  logic                        rst_n,
  input  icache_addr_pkg::fetch_req_s rd_req,
  input  icache_line_pkg::line_t      fill_line,
  input  icache_addr_pkg::index_t     fill_index,
  input  icache_addr_pkg::tag_t       fill_tag,
  input  icache_line_pkg::way_ctl_s   ctl,
  output logic                        hit,
  output icache_line_pkg::way_entry_s entry,
  output icache_line_pkg::age_t       age
);
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  logic [`ICACHE_SETS-1:0] valid_q;
  tag_t                    tag_mem [`ICACHE_SETS];
  line_t                   line_mem [`ICACHE_SETS];
  age_t                    age_q [`ICACHE_SETS];

  index_t rd_index_q;
  tag_t   req_tag_q;
  logic   rd_valid_q;
  tag_t   rd_tag_q;
  line_t  rd_line_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        age_q[s] <= '0;
      end
    end else begin
      if (ctl.fill) begin
        valid_q[fill_index] <= 1'b1;
      end
      // ages move on the set held from the last lookup
      if (ctl.touch) begin
        age_q[rd_index_q] <= '0;
      end else if (ctl.age_up && age_q[rd_index_q] != '1) begin
        age_q[rd_index_q] <= age_q[rd_index_q] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.fill) begin
      tag_mem[fill_index]  <= fill_tag;
      line_mem[fill_index] <= fill_line;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else if (rd_req.req) begin
      rd_valid_q <= valid_q[addr_index(rd_req.addr)];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req.req) begin
      rd_index_q <= addr_index(rd_req.addr);
      req_tag_q  <= addr_tag(rd_req.addr);
      rd_tag_q   <= tag_mem[addr_index(rd_req.addr)];
      rd_line_q  <= line_mem[addr_index(rd_req.addr)];
    end
  end

  assign hit   = rd_valid_q && (rd_tag_q == req_tag_q);
  assign entry = '{valid: rd_valid_q, tag: rd_tag_q, line: rd_line_q};
  assign age   = age_q[rd_index_q];

endmodule

// File: hdl/icache_front.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_front (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ins_req,
  input  icache_addr_pkg::addr_t      cpu_addr,
  input  logic                        miss,
  output icache_addr_pkg::fetch_req_s rd_req,
  output icache_addr_pkg::addr_t      held_addr,
  output icache_line_pkg::line_t      fill_line,
  output logic                        refilling,
  output logic                        dram_req,
  output icache_addr_pkg::addr_t      dram_addr,
  input  icache_addr_pkg::word_t      dram_data,
  input  logic                        dram_val
);
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  refill_state_e state_q;
  refill_state_e state_d;
  addr_t         held_q;
  line_t         line_q;
  word_sel_t     beat_q;
  logic          beat_in;
  logic          last_beat;

  assign beat_in   = (state_q == REQUEST) && dram_val;
  assign last_beat = beat_in && (beat_q == word_sel_t'(`ICACHE_LINE_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (miss) state_d = REQUEST;
      REQUEST: if (last_beat) state_d = WRITE;
      WRITE:   state_d = REPLAY;
      REPLAY:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      // wraps to zero after the last beat
      if (beat_in) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // address stays put from the miss until the replay
  always_ff @(posedge clk) begin
    if (ins_req && state_q == IDLE) begin
      held_q <= cpu_addr;
    end
  end

  // newest beat enters at the top and the first beat ends in word 0
  always_ff @(posedge clk) begin
    if (beat_in) begin
      line_q <= {dram_data, line_q[`ICACHE_LINE_WORDS-1:1]};
    end
  end

  always_comb begin
    if (state_q == REPLAY) begin
      rd_req = '{req: 1'b1, addr: held_q};
    end else begin
      rd_req = '{req: ins_req && (state_q == IDLE), addr: cpu_addr};
    end
  end

  assign held_addr = held_q;
  assign fill_line = line_q;
  assign refilling = (state_q != IDLE);
  assign dram_req  = (state_q == REQUEST);
  assign dram_addr = line_addr(held_q);

endmodule

// File: hdl/icache_select.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_select (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  icache_addr_pkg::addr_t                         held_addr,
  input  logic                                           pending,
  input  logic                                           refilling,
  input  logic [`ICACHE_WAYS-1:0]                        hit,
  input  icache_line_pkg::way_entry_s [`ICACHE_WAYS-1:0] entry,
  input  icache_line_pkg::age_t [`ICACHE_WAYS-1:0]       age,
  output icache_line_pkg::way_ctl_s [`ICACHE_WAYS-1:0]   ctl,
  output logic                                           miss,
  output logic                                           abort,
  output icache_addr_pkg::word_t                         instruction
);
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  logic                    lookup_q;
  logic                    any_hit;
  logic [`ICACHE_WAYS-1:0] victim_d;
  logic [`ICACHE_WAYS-1:0] victim_q;

  // ways answer one cycle after the read request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lookup_q <= 1'b0;
    end else begin
      lookup_q <= pending;
    end
  end

  assign any_hit = |hit;
  assign miss    = lookup_q && !any_hit;
  assign abort   = miss || refilling;

  always_comb begin
    line_t sel_line;
    sel_line = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit[w]) sel_line = entry[w].line;
    end
    instruction = sel_line[addr_word(held_addr)];
  end

  // lowest invalid way overrides the oldest way with ties to the higher number
  always_comb begin
    int pick;
    pick = `ICACHE_WAYS - 1;
    for (int w = `ICACHE_WAYS - 2; w >= 0; w--) begin
      if (age[w] > age[pick]) pick = w;
    end
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!entry[w].valid) pick = w;
    end
    victim_d       = '0;
    victim_d[pick] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      victim_q <= victim_d;
    end
  end

  // victim follows the collected beats until the WRITE cycle stores the full line
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      ctl[w].fill   = victim_q[w] && refilling && !pending;
      ctl[w].touch  = lookup_q && hit[w];
      ctl[w].age_up = lookup_q && any_hit && !hit[w];
    end
  end

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ins_req,
  input  icache_addr_pkg::addr_t cpu_addr,
  output icache_addr_pkg::word_t instruction,
  output logic                   abort,
  output logic                   dram_req,
  output icache_addr_pkg::addr_t dram_addr,
  input  icache_addr_pkg::word_t dram_data,
  input  logic                   dram_val
);
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  fetch_req_s                   rd_req;
  addr_t                        held_addr;
  line_t                        fill_line;
  index_t                       fill_index;
  tag_t                         fill_tag;
  logic                         refilling;
  logic                         miss;
  logic [`ICACHE_WAYS-1:0]      hit;
  way_entry_s [`ICACHE_WAYS-1:0] entry;
  age_t [`ICACHE_WAYS-1:0]      age;
  way_ctl_s [`ICACHE_WAYS-1:0]  ctl;

  assign fill_index = addr_index(held_addr);
  assign fill_tag   = addr_tag(held_addr);

  icache_front i_front (
    .clk       (clk),
    .rst_n     (rst_n),
    .ins_req   (ins_req),
    .cpu_addr  (cpu_addr),
    .miss      (miss),
    .rd_req    (rd_req),
    .held_addr (held_addr),
    .fill_line (fill_line),
    .refilling (refilling),
    .dram_req  (dram_req),
    .dram_addr (dram_addr),
    .dram_data (dram_data),
    .dram_val  (dram_val)
  );

  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
    icache_way i_way (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_req     (rd_req),
      .fill_line  (fill_line),
      .fill_index (fill_index),
      .fill_tag   (fill_tag),
      .ctl        (ctl[g]),
      .hit        (hit[g]),
      .entry      (entry[g]),
      .age        (age[g])
    );
  end

  icache_select i_select (
    .clk         (clk),
    .rst_n       (rst_n),
    .held_addr   (held_addr),
    .pending     (rd_req.req),
    .refilling   (refilling),
    .hit         (hit),
    .entry       (entry),
    .age         (age),
    .ctl         (ctl),
    .miss        (miss),
    .abort       (abort),
    .instruction (instruction)
  );

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;
  import icache_addr_pkg::*;

  localparam int MAX_ACCESS = 64;
  localparam int FIELDS = 5;
  localparam int CYCLES_PER_ACCESS = 40;

  logic  clk = 1'b0;
  logic  rst_n = 1'b0;
  logic  ins_req = 1'b0;
  addr_t cpu_addr = '0;
  word_t instruction;
  logic  abort;
  logic  dram_req;
  addr_t dram_addr;
  word_t dram_data = '0;
  logic  dram_val = 1'b0;

  // test id, reset flag, address, instruction, miss flag per access
  logic [63:0] golden [MAX_ACCESS*FIELDS];
  int          num_access = 0;
  int          cycle_limit = 0;
  int          cycle_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  // DRAM model state
  int    seed = 95;
  int    req_rises = 0;
  addr_t req_addr = '0;
  logic  req_seen = 1'b0;
  int    beats_sent = 0;
  int    gap_left = 0;

  icache_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .ins_req     (ins_req),
    .cpu_addr    (cpu_addr),
    .instruction (instruction),
    .abort       (abort),
    .dram_req    (dram_req),
    .dram_addr   (dram_addr),
    .dram_data   (dram_data),
    .dram_val    (dram_val)
  );

  always #50 clk = ~clk;

  // beat contents are the beat address and its complement
  function automatic word_t dram_beat(addr_t a);
    return {~a, a};
  endfunction

  function automatic string behavior_name(int id);
    case (id)
      1: return "cold_miss";
      2: return "line_hits";
      3: return "second_way";
      4: return "age_evict";
      5: return "other_sets";
      6: return "reset_flush";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      dram_val   <= 1'b0;
      req_seen   = 1'b0;
      beats_sent = 0;
    end else begin
      dram_val <= 1'b0;
      if (dram_req && !req_seen) begin
        req_rises  = req_rises + 1;
        req_addr   = dram_addr;
        beats_sent = 0;
        gap_left   = $random(seed) & 3;
      end
      req_seen = dram_req;
      if (dram_req && beats_sent < `ICACHE_LINE_WORDS) begin
        if (gap_left == 0) begin
          dram_val   <= 1'b1;
          dram_data  <= dram_beat(dram_addr + addr_t'(beats_sent * 8));
          beats_sent = beats_sent + 1;
          gap_left   = $random(seed) & 3;
        end else begin
          gap_left = gap_left - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout, no fetch result after %0d cycles", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic run_access(input int n);
    int    base;
    int    id;
    int    exp_miss;
    int    rises_before;
    int    rises;
    int    waited;
    addr_t addr;
    addr_t exp_line;
    word_t expected;
    string name;
    logic  ok;
    base     = n * FIELDS;
    id       = int'(golden[base][7:0]);
    addr     = golden[base+2][31:0];
    expected = golden[base+3];
    exp_miss = int'(golden[base+4][0]);
    exp_line = addr & 32'hffff_ffe0;
    name     = $sformatf("%s_%0d", behavior_name(id), n);
    ok       = 1'b1;
    if (golden[base+1][0]) begin
      apply_reset();
    end
    @(negedge clk);
    while (abort) begin
      @(negedge clk);
    end
    rises_before = req_rises;
    @(posedge clk);
    ins_req  <= 1'b1;
    cpu_addr <= addr;
    @(posedge clk);
    ins_req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (abort) begin
      waited = waited + 1;
      @(negedge clk);
    end
    rises = req_rises - rises_before;
    if (instruction !== expected) begin
      $display("FAILED %s: instruction expected %h actual %h", name, expected, instruction);
      ok = 1'b0;
    end
    if (rises != exp_miss) begin
      $display("FAILED %s: dram requests expected %0d actual %0d", name, exp_miss, rises);
      ok = 1'b0;
    end
    if (rises > 0 && req_addr !== exp_line) begin
      $display("FAILED %s: dram_addr expected %h actual %h", name, exp_line, req_addr);
      ok = 1'b0;
    end
    if (exp_miss == 0 && waited != 0) begin
      $display("FAILED %s: hit latency expected 1 actual %0d", name, waited + 1);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count = pass_count + 1;
      $display("passed %s at %h", name, addr);
    end else begin
      fail_count = fail_count + 1;
    end
  endtask

  initial begin
    // unused slots are marked by all ones in the upper half
    for (int i = 0; i < MAX_ACCESS * FIELDS; i++) begin
      golden[i] = {32'hffff_ffff, i};
    end
    $readmemh("tb/icache_golden.txt", golden);
    while (num_access < MAX_ACCESS && golden[num_access*FIELDS][63:32] != 32'hffff_ffff) begin
      num_access = num_access + 1;
    end
    cycle_limit = CYCLES_PER_ACCESS * num_access;
    if (num_access == 0) begin
      $display("no accesses could be read from tb/icache_golden.txt");
      fail_count = fail_count + 1;
    end else begin
      apply_reset();
      for (int n = 0; n < num_access; n++) begin
        run_access(n);
      end
    end
    $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb/icache_golden.txt
// columns: test id, reset flag, fetch address, expected instruction, expected miss
// test ids: 1 cold miss, 2 line hits, 3 second way, 4 age eviction, 5 other sets, 6 reset
1 0 000008a8 fffff757000008a8 1
2 0 000008a0 fffff75f000008a0 0
2 0 000008a8 fffff757000008a8 0
2 0 000008b0 fffff74f000008b0 0
2 0 000008b8 fffff747000008b8 0
3 0 000010b0 ffffef4f000010b0 1
3 0 000008b8 fffff747000008b8 0
3 0 000010a0 ffffef5f000010a0 0
3 0 000010b8 ffffef47000010b8 0
4 0 000018a8 ffffe757000018a8 1
4 0 000010a8 ffffef57000010a8 0
4 0 000018b8 ffffe747000018b8 0
4 0 000008a0 fffff75f000008a0 1
4 0 000018a0 ffffe75f000018a0 0
4 0 000010a0 ffffef5f000010a0 1
5 0 00000808 fffff7f700000808 1
5 0 00000ff8 fffff00700000ff8 1
5 0 80001150 7fffeeaf80001150 1
5 0 000018b0 ffffe74f000018b0 0
5 0 000010b8 ffffef47000010b8 0
5 0 00000800 fffff7ff00000800 0
5 0 00000fe0 fffff01f00000fe0 0
5 0 80001158 7fffeea780001158 0
6 1 000018b0 ffffe74f000018b0 1
6 0 00000808 fffff7f700000808 1
6 0 000018a8 ffffe757000018a8 0

// File: verilog.f
+incdir+hdl
hdl/icache_addr_pkg.sv
hdl/icache_line_pkg.sv
hdl/icache_way.sv
hdl/icache_front.sv
hdl/icache_select.sv
hdl/icache_top.sv
tb/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module icache_tb \
  -f verilog.f

./obj_dir/Vicache_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim.sh: testbench reported failure, see sim.log"
  exit 1
fi
exit 0
